// ==== sign_scalar.f ====
source/sign_pkg.sv
source/mult_pipe.sv
source/barrett_reduce.sv
source/scratch_ram.sv
source/sign_sequencer.sv
source/sign_scalar_core.sv
bench/sign_scalar_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing -Wno-fatal -f sign_scalar.f \
    --top-module sign_scalar_tb -o sim_sign_scalar

./obj_dir/sim_sign_scalar 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation log shows no failure"

// ==== bench/sign_scalar_tb.sv ====
module sign_scalar_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS       = 50; // reset, 40 random, 7 edge cases, 2 chained.
    localparam int CYCLES_PER_TEST = 200;
    localparam int CLK_PERIOD      = 100;

    logic                clk;
    logic                rst;
    logic                ena;
    sign_pkg::sign_req_t req;
    logic                ready;
    logic                comp_done;
    sign_pkg::scalar_t   s;
    integer              seed;

    sign_scalar_core sign_scalar_core_i (
        .clk       (clk),
        .rst       (rst),
        .ena       (ena),
        .req       (req),
        .ready     (ready),
        .comp_done (comp_done),
        .s         (s)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [255:0] actual,
                               input logic [255:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h expected %h", name, actual, expected);
            $display("Verification failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // reference result (r + k*a) mod L worked out on 768-bit values.
    function automatic sign_pkg::scalar_t expected_s(input sign_pkg::sign_req_t r);
        logic [767:0] l_w;
        logic [767:0] r_m;
        logic [767:0] k_m;
        logic [767:0] ka;
        logic [767:0] sum;
        l_w = 768'(sign_pkg::ORDER_L);
        r_m = 768'(r.r_digest) % l_w;
        k_m = 768'(r.k_digest) % l_w;
        ka  = (k_m * 768'(r.secret_a)) % l_w;
        sum = (r_m + ka) % l_w;
        return sign_pkg::scalar_t'(sum);
    endfunction

    function automatic sign_pkg::wide_t random_wide();
        sign_pkg::wide_t w;
        for (int i = 0; i < 16; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    function automatic sign_pkg::sign_req_t random_req();
        sign_pkg::sign_req_t r;
        sign_pkg::wide_t     w;
        r.r_digest = random_wide();
        r.k_digest = random_wide();
        w          = random_wide();
        r.secret_a = w[255:0];
        return r;
    endfunction

    // the start edge is the second rising edge after ready is seen.
    task automatic start_req(input sign_pkg::sign_req_t r);
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        ena <= 1'b1;
        req <= r;
        @(posedge clk);
        ena <= 1'b0;
    endtask

    task automatic await_done(input sign_pkg::scalar_t expected);
        @(negedge clk);
        while (!comp_done) begin
            check_value("ready", 256'(ready), 256'(0)); // busy until the result is out.
            @(negedge clk);
        end
        check_value("s", 256'(s), 256'(expected));
        @(negedge clk);
        check_value("comp_done", 256'(comp_done), 256'(0)); // a single-cycle pulse.
    endtask

    task automatic hold_idle(input sign_pkg::scalar_t expected, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("s", 256'(s), 256'(expected));
            check_value("comp_done", 256'(comp_done), 256'(0));
            check_value("ready", 256'(ready), 256'(1));
        end
    endtask

    task automatic run_case(input sign_pkg::wide_t r_d, input sign_pkg::wide_t k_d,
                            input logic [255:0] a_v);
        sign_pkg::sign_req_t r;
        r.r_digest = r_d;
        r.k_digest = k_d;
        r.secret_a = a_v;
        start_req(r);
        await_done(expected_s(r));
        hold_idle(expected_s(r), 2);
    endtask

    initial begin
        sign_pkg::sign_req_t r;
        sign_pkg::sign_req_t r_next;
        sign_pkg::wide_t     w;
        int                  gap;
        seed = 32'he02a87cd;
        rst <= 1'b1;
        ena <= 1'b0;
        req <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("ready", 256'(ready), 256'(1));
        check_value("comp_done", 256'(comp_done), 256'(0));
        check_value("s", 256'(s), 256'(0));

        for (int i = 0; i < 40; i++) begin
            r   = random_req();
            gap = {$random(seed)} % 4;
            start_req(r);
            await_done(expected_s(r));
            hold_idle(expected_s(r), gap + 1);
        end

        w = random_wide();
        run_case('0, '0, '0);
        run_case('1, '1, w[255:0]);
        run_case(sign_pkg::wide_t'(sign_pkg::ORDER_L) - 512'd1, '0, '0);
        run_case(sign_pkg::wide_t'(sign_pkg::ORDER_L), random_wide(), w[511:256]);
        run_case(random_wide(), random_wide(), '0);
        run_case(random_wide(), random_wide(), '1);
        run_case('1, '1, '1);

        // ena stays high with a second request while the first one runs.
        r      = random_req();
        r_next = random_req();
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        ena <= 1'b1;
        req <= r;
        @(posedge clk);
        req <= r_next;
        await_done(expected_s(r));
        check_value("ready", 256'(ready), 256'(0)); // second request already taken.
        @(posedge clk);
        ena <= 1'b0;
        await_done(expected_s(r_next));
        hold_idle(expected_s(r_next), 3);

        $display("Verification passed");
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the DUT did not finish all requests in the expected time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== source/sign_scalar_core.sv ====
module sign_scalar_core #(
    parameter int MULT_STAGES = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ena,
    input  sign_pkg::sign_req_t req,
    output logic                ready,
    output logic                comp_done,
    output sign_pkg::scalar_t   s
);

    logic                red_start;
    sign_pkg::wide_t     red_in;
    logic                red_done;
    sign_pkg::scalar_t   red_out;
    sign_pkg::mult_req_t red_mult_req;
    sign_pkg::mult_req_t mult_req;
    sign_pkg::mult_rsp_t mult_rsp;
    logic                ram_we;
    sign_pkg::slot_t     ram_waddr;
    sign_pkg::scalar_t   ram_wdata;
    sign_pkg::slot_t     ram_raddr;
    sign_pkg::scalar_t   ram_rdata;

    sign_sequencer #(.MULT_STAGES(MULT_STAGES)) sign_sequencer_i (
        .clk          (clk),
        .rst          (rst),
        .ena          (ena),
        .req          (req),
        .ready        (ready),
        .comp_done    (comp_done),
        .s            (s),
        .red_start    (red_start),
        .red_in       (red_in),
        .red_done     (red_done),
        .red_out      (red_out),
        .red_mult_req (red_mult_req),
        .mult_req     (mult_req),
        .mult_rsp     (mult_rsp),
        .ram_we       (ram_we),
        .ram_waddr    (ram_waddr),
        .ram_wdata    (ram_wdata),
        .ram_raddr    (ram_raddr),
        .ram_rdata    (ram_rdata)
    );

    mult_pipe #(.MULT_STAGES(MULT_STAGES)) mult_pipe_i (
        .clk (clk),
        .rst (rst),
        .req (mult_req),
        .rsp (mult_rsp)
    );

    barrett_reduce #(.MULT_STAGES(MULT_STAGES)) barrett_reduce_i (
        .clk       (clk),
        .rst       (rst),
        .red_start (red_start),
        .red_in    (red_in),
        .red_done  (red_done),
        .red_out   (red_out),
        .mult_req  (red_mult_req),
        .mult_rsp  (mult_rsp)
    );

    scratch_ram scratch_ram_i (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

endmodule

// ==== source/sign_sequencer.sv ====
module sign_sequencer #(
    parameter int MULT_STAGES = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ena,
    input  sign_pkg::sign_req_t req,
    output logic                ready,
    output logic                comp_done,
    output sign_pkg::scalar_t   s,
    output logic                red_start,
    output sign_pkg::wide_t     red_in,
    input  logic                red_done,
    input  sign_pkg::scalar_t   red_out,
    input  sign_pkg::mult_req_t red_mult_req,
    output sign_pkg::mult_req_t mult_req,
    input  sign_pkg::mult_rsp_t mult_rsp,
    output logic                ram_we,
    output sign_pkg::slot_t     ram_waddr,
    output sign_pkg::scalar_t   ram_wdata,
    output sign_pkg::slot_t     ram_raddr,
    input  sign_pkg::scalar_t   ram_rdata
);

    localparam int CW = $clog2(MULT_STAGES + 1);

    sign_pkg::seq_state_t state;
    sign_pkg::sign_req_t  req_reg;
    sign_pkg::wide_t      red_src;
    logic                 red_busy;
    logic                 k_loaded;
    logic                 mul_issued;
    logic [CW-1:0]        wait_cnt;

    assign ready     = (state == sign_pkg::SEQ_IDLE);
    assign red_start = !red_busy && (state inside {sign_pkg::SEQ_RED_R, sign_pkg::SEQ_RED_K,
                                                   sign_pkg::SEQ_RED_KA, sign_pkg::SEQ_RED_SUM});
    assign ram_we    = red_done; // every reduced value lands in its slot.
    assign ram_wdata = red_out;

    always_comb begin
        case (state)
            sign_pkg::SEQ_RED_R: red_in = req_reg.r_digest;
            sign_pkg::SEQ_RED_K: red_in = req_reg.k_digest;
            default:             red_in = red_src;
        endcase
    end

    always_comb begin
        case (state)
            sign_pkg::SEQ_RED_R:  ram_waddr = sign_pkg::SLOT_R;
            sign_pkg::SEQ_RED_K:  ram_waddr = sign_pkg::SLOT_K;
            sign_pkg::SEQ_RED_KA: ram_waddr = sign_pkg::SLOT_KA;
            default:              ram_waddr = sign_pkg::SLOT_SUM;
        endcase
    end

    // slot r is read during the ka reduction so it is ready for the add.
    always_comb begin
        case (state)
            sign_pkg::SEQ_MUL_KA:  ram_raddr = sign_pkg::SLOT_K;
            sign_pkg::SEQ_RED_KA:  ram_raddr = sign_pkg::SLOT_R;
            sign_pkg::SEQ_ADD:     ram_raddr = sign_pkg::SLOT_R;
            default:               ram_raddr = sign_pkg::SLOT_SUM;
        endcase
    end

    always_comb begin
        if (state == sign_pkg::SEQ_MUL_KA) begin
            mult_req.valid = k_loaded && !mul_issued;
            mult_req.a     = sign_pkg::operand_t'(ram_rdata);
            mult_req.b     = sign_pkg::operand_t'(req_reg.secret_a);
        end else begin
            mult_req = red_mult_req; // the reduction unit owns the multiplier.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= sign_pkg::SEQ_IDLE;
            red_busy   <= 1'b0;
            k_loaded   <= 1'b0;
            mul_issued <= 1'b0;
            wait_cnt   <= '0;
            comp_done  <= 1'b0;
            s          <= '0;
        end else begin
            comp_done <= 1'b0;
            if (red_start) begin
                red_busy <= 1'b1;
            end else if (red_done) begin
                red_busy <= 1'b0;
            end
            case (state)
                sign_pkg::SEQ_IDLE: begin
                    if (ena) begin
                        state <= sign_pkg::SEQ_RED_R;
                    end
                end
                sign_pkg::SEQ_RED_R: begin
                    if (red_done) begin
                        state <= sign_pkg::SEQ_RED_K;
                    end
                end
                sign_pkg::SEQ_RED_K: begin
                    if (red_done) begin
                        state <= sign_pkg::SEQ_MUL_KA;
                    end
                end
                sign_pkg::SEQ_MUL_KA: begin
                    k_loaded <= 1'b1;
                    if (mult_req.valid) begin
                        mul_issued <= 1'b1;
                        wait_cnt   <= CW'(MULT_STAGES - 1);
                    end else if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - CW'(1);
                    end
                    if (mul_issued && wait_cnt == '0 && mult_rsp.valid) begin
                        k_loaded   <= 1'b0;
                        mul_issued <= 1'b0;
                        state      <= sign_pkg::SEQ_RED_KA;
                    end
                end
                sign_pkg::SEQ_RED_KA: begin
                    if (red_done) begin
                        state <= sign_pkg::SEQ_ADD;
                    end
                end
                sign_pkg::SEQ_ADD: begin
                    state <= sign_pkg::SEQ_RED_SUM;
                end
                sign_pkg::SEQ_RED_SUM: begin
                    if (red_done) begin
                        state <= sign_pkg::SEQ_OUTPUT;
                    end
                end
                sign_pkg::SEQ_OUTPUT: begin
                    s         <= red_out;
                    comp_done <= 1'b1;
                    state     <= sign_pkg::SEQ_IDLE;
                end
                default: begin
                    state <= sign_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sign_pkg::SEQ_IDLE && ena) begin
            req_reg <= req;
        end
        if (state == sign_pkg::SEQ_MUL_KA && mul_issued && wait_cnt == '0 && mult_rsp.valid) begin
            red_src <= sign_pkg::wide_t'(mult_rsp.product); // k times a fits in 509 bits.
        end
        if (state == sign_pkg::SEQ_ADD) begin
            red_src <= sign_pkg::wide_t'({1'b0, ram_rdata} + {1'b0, red_out});
        end
    end

endmodule

// ==== source/scratch_ram.sv ====
module scratch_ram (
    input  logic              clk,
    input  logic              we,
    input  sign_pkg::slot_t   waddr,
    input  sign_pkg::scalar_t wdata,
    input  sign_pkg::slot_t   raddr,
    output sign_pkg::scalar_t rdata
);

    sign_pkg::scalar_t mem [4];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // a write and a read of the same slot on one edge return the old value.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== source/barrett_reduce.sv ====
module barrett_reduce #(
    parameter int MULT_STAGES = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                red_start,
    input  sign_pkg::wide_t     red_in,
    output logic                red_done,
    output sign_pkg::scalar_t   red_out,
    output sign_pkg::mult_req_t mult_req,
    input  sign_pkg::mult_rsp_t mult_rsp
);

    localparam int CW = $clog2(MULT_STAGES + 1);
    localparam logic [254:0] L_EXT = 255'(sign_pkg::ORDER_L);

    sign_pkg::red_state_t state;
    logic [CW-1:0]        wait_cnt;
    logic                 rsp_ours;
    sign_pkg::wide_t      x_reg;
    sign_pkg::operand_t   quot;
    logic [254:0]         rem;
    logic [254:0]         fixed;

    // the remainder stays below 3L, so 255 bits hold it without wrap.
    assign rsp_ours = mult_rsp.valid && (wait_cnt == '0);
    assign fixed    = (rem >= L_EXT) ? rem - L_EXT : rem;

    always_comb begin
        mult_req.valid = (state == sign_pkg::RED_MU) || (state == sign_pkg::RED_QL);
        if (state == sign_pkg::RED_QL) begin
            mult_req.a = quot;
            mult_req.b = sign_pkg::operand_t'(sign_pkg::ORDER_L);
        end else begin
            mult_req.a = sign_pkg::operand_t'(x_reg >> sign_pkg::BARRETT_SHIFT_IN);
            mult_req.b = sign_pkg::operand_t'(sign_pkg::BARRETT_MU);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= sign_pkg::RED_IDLE;
            wait_cnt <= '0;
            red_done <= 1'b0;
        end else begin
            red_done <= 1'b0;
            case (state)
                sign_pkg::RED_IDLE: begin
                    if (red_start) begin
                        state <= sign_pkg::RED_MU;
                    end
                end
                sign_pkg::RED_MU: begin
                    wait_cnt <= CW'(MULT_STAGES - 1);
                    state    <= sign_pkg::RED_WAIT_MU;
                end
                sign_pkg::RED_WAIT_MU: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - CW'(1);
                    end
                    if (rsp_ours) begin
                        state <= sign_pkg::RED_QL;
                    end
                end
                sign_pkg::RED_QL: begin
                    wait_cnt <= CW'(MULT_STAGES - 1);
                    state    <= sign_pkg::RED_WAIT_QL;
                end
                sign_pkg::RED_WAIT_QL: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - CW'(1);
                    end
                    if (rsp_ours) begin
                        state <= sign_pkg::RED_SUB1;
                    end
                end
                sign_pkg::RED_SUB1: begin
                    state <= sign_pkg::RED_SUB2;
                end
                sign_pkg::RED_SUB2: begin
                    red_done <= 1'b1;
                    state    <= sign_pkg::RED_IDLE;
                end
                default: begin
                    state <= sign_pkg::RED_IDLE;
                end
            endcase
        end
    end

    // red_out holds until the next reduction, the sequencer reads it in its add step.
    always_ff @(posedge clk) begin
        if (state == sign_pkg::RED_IDLE && red_start) begin
            x_reg <= red_in;
        end
        if (state == sign_pkg::RED_WAIT_MU && rsp_ours) begin
            quot <= sign_pkg::operand_t'(mult_rsp.product >> sign_pkg::BARRETT_SHIFT_OUT);
        end
        if (state == sign_pkg::RED_WAIT_QL && rsp_ours) begin
            rem <= x_reg[254:0] - mult_rsp.product[254:0];
        end
        if (state == sign_pkg::RED_SUB1) begin
            rem <= fixed;
        end
        if (state == sign_pkg::RED_SUB2) begin
            red_out <= sign_pkg::scalar_t'(fixed);
        end
    end

endmodule

// ==== source/mult_pipe.sv ====
module mult_pipe #(
    parameter int MULT_STAGES = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  sign_pkg::mult_req_t req,
    output sign_pkg::mult_rsp_t rsp
);

    sign_pkg::mult_rsp_t pipe [MULT_STAGES];

    always_ff @(posedge clk) begin
        pipe[0].product <= sign_pkg::product_t'(req.a) * sign_pkg::product_t'(req.b);
        for (int i = 1; i < MULT_STAGES; i++) begin
            pipe[i].product <= pipe[i - 1].product;
        end
        if (rst) begin
            for (int i = 0; i < MULT_STAGES; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end else begin
            pipe[0].valid <= req.valid;
            for (int i = 1; i < MULT_STAGES; i++) begin
                pipe[i].valid <= pipe[i - 1].valid;
            end
        end
    end

    assign rsp = pipe[MULT_STAGES - 1]; // last stage faces both users.

endmodule

// ==== source/sign_pkg.sv ====
package sign_pkg;

    typedef logic [263:0] operand_t;
    typedef logic [527:0] product_t;
    typedef logic [511:0] wide_t;
    typedef logic [252:0] scalar_t;

    typedef struct packed {
        logic     valid;
        operand_t a;
        operand_t b;
    } mult_req_t;

    typedef struct packed {
        logic     valid;
        product_t product;
    } mult_rsp_t;

    typedef struct packed {
        wide_t        r_digest;
        wide_t        k_digest;
        logic [255:0] secret_a;
    } sign_req_t;

    typedef enum logic [1:0] {SLOT_R, SLOT_K, SLOT_KA, SLOT_SUM} slot_t;

    typedef enum logic [2:0] {
        SEQ_IDLE, SEQ_RED_R, SEQ_RED_K, SEQ_MUL_KA,
        SEQ_RED_KA, SEQ_ADD, SEQ_RED_SUM, SEQ_OUTPUT
    } seq_state_t;

    typedef enum logic [2:0] {
        RED_IDLE, RED_MU, RED_WAIT_MU, RED_QL, RED_WAIT_QL, RED_SUB1, RED_SUB2
    } red_state_t;

    localparam scalar_t ORDER_L =
        253'h1000000000000000000000000000000014def9dea2f79cd65812631a5cf5d3ed;

    // the digests use all 512 bits, so mu is taken over 2^512 to keep the
    // quotient estimate within two of the true quotient.
    localparam logic [512:0] BARRETT_RADIX = 513'b1 << 512;
    localparam logic [259:0] BARRETT_MU = 260'(BARRETT_RADIX / 513'(ORDER_L));

    localparam int BARRETT_SHIFT_IN  = 252;
    localparam int BARRETT_SHIFT_OUT = 260;

endpackage
